// ==== design/lane_lock_config.svh ====
// Lane lock timing constants; include wherever a block needs a strobe tap or count
`ifndef LANE_LOCK_CONFIG_SVH
`define LANE_LOCK_CONFIG_SVH

// Control clocks per base strobe, stands in for the 1 us base
`define LL_TICK_DIV      16
// Strobes in the timing family, each twice the period of the one below
`define LL_PULSE_W       8

// Debounce mask after a lock has been seen, 128 cycles
`define LL_DEBOUNCE_TAP  3
// Separate initial quiet time from power-up, 32 cycles
`define LL_IQUIET_WAIT   1
`define LL_IQUIET_TAP    1
// Two-strobe delay before the first normal mode request
`define LL_ILOCK_WAIT    1
`define LL_ILOCK_TAP     1

// Signal detect window, 64 cycles
`define LL_WIN_TAP       2
// Non-idle cycles per window that count as signal, half the window
`define LL_SIG_MIN       32
`define LL_INTG_W        7

// Lane master settling time for a CDR mode change
`define LL_SETTLE_CYC    6

`endif

// ==== design/lane_lock_pkg.sv ====
// Shared types of the lane lock manager; import into any block that carries them
`include "lane_lock_config.svh"

package lane_lock_pkg;

    // Timing strobe family, bit k every LL_TICK_DIV * 2**k cycles
    typedef logic [`LL_PULSE_W-1:0] pulse_t;

    // Non-idle cycle count within one window
    typedef logic [`LL_INTG_W-1:0] intg_t;

    // Lane master settling countdown
    typedef logic [2:0] settle_t;

    // Lock FSM states
    typedef enum logic [2:0] {
        req_l2r = 3'd0,
        qpkdet  = 3'd1,
        winrst  = 3'd2,
        wincnt  = 3'd3,
        iplck1  = 3'd4,
        iplck2  = 3'd5,
        req_nrm = 3'd6,
        cdr_nrm = 3'd7
    } lock_state_e;

endpackage

// ==== design/link_timer.sv ====
// Link timer; free-running source of the doubling timing strobes for the lock manager
`timescale 1ns/1ns
`include "lane_lock_config.svh"

module link_timer import lane_lock_pkg::*; (
    input  logic   ctrl_clk,
    input  logic   ctrl_srst_n,
    output pulse_t timing_pulse
);

    localparam int PRESC_W = $clog2(`LL_TICK_DIV);

    // Prescaler, wraps every LL_TICK_DIV cycles
    logic [PRESC_W-1:0] presc;
    logic               tick;

    // Binary divider, one bit fewer than the strobe family
    // Bit 0 of the family is the prescaler tick itself
    logic [`LL_PULSE_W-2:0] div;

    // Rollover chain, bit k set when div[k-1:0] all wrap on this tick
    pulse_t carry;

    assign tick = (presc == PRESC_W'(`LL_TICK_DIV - 1));

    always_comb begin
        carry[0] = tick;
        for (int k = 1; k < `LL_PULSE_W; k++) begin
            carry[k] = carry[k-1] & div[k-1];
        end
    end

    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            presc <= '0;
        end else if (tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // Divider advances once per prescaler wrap
    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            div <= '0;
        end else if (tick) begin
            div <= div + 1'b1;
        end
    end

    // Registered strobes, clean single cycles
    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            timing_pulse <= '0;
        end else begin
            timing_pulse <= carry;
        end
    end

endmodule

// ==== design/lane_sync_in.sv ====
// Input side; brings receiver idle and link-up into the control clock and flags link loss
`timescale 1ns/1ns

module lane_sync_in (
    input  logic ctrl_clk,
    input  logic ctrl_srst_n,
    input  logic rx_idle,
    input  logic sync,
    output logic rx_idle_sync,
    output logic sync_fall
);

    // Two-flop synchronizer for the transceiver idle flag
    logic [1:0] idle_q;

    // Link-up history, newest in bit 0
    logic [2:0] sync_q;

    // Idle assumed until the first real sample arrives
    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            idle_q <= 2'b11;
        end else begin
            idle_q <= {idle_q[0], rx_idle};
        end
    end

    assign rx_idle_sync = idle_q[1];

    // Link-up treated as down out of reset, so no false fall
    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            sync_q    <= 3'b000;
            sync_fall <= 1'b0;
        end else begin
            sync_q    <= {sync_q[1:0], sync};
            // Falling edge seen between the two oldest stages
            sync_fall <= sync_q[2] & ~sync_q[1];
        end
    end

endmodule

// ==== design/lock_manager.sv ====
// Lane lock manager FSM; decides when the CDR leaves and returns to lock-to-reference
`timescale 1ns/1ns
`include "lane_lock_config.svh"

module lock_manager import lane_lock_pkg::*; (
    input  logic   ctrl_clk,
    input  logic   ctrl_srst_n,
    input  pulse_t timing_pulse,
    input  logic   rx_idle_sync,
    input  logic   sync_fall,
    input  logic   calib_sync_hold,
    input  logic   lock_ack,
    output logic   lock_req
);

    lock_state_e state, state_nx;

    // Non-idle cycles seen in the current window
    intg_t intg, intg_nx;

    // Set until the CDR has reached normal mode once
    logic never_locked, never_locked_nx;

    logic lock_req_nx;

    // Qualified strobes
    logic tp_mask;
    logic tp_win;
    logic tp_lckdly;
    logic min_signal;

    // Shorter quiet time only before the first lock
    always_comb begin
        if (never_locked && (`LL_IQUIET_WAIT == 1)) begin
            tp_mask = timing_pulse[`LL_IQUIET_TAP];
        end else begin
            tp_mask = timing_pulse[`LL_DEBOUNCE_TAP];
        end
    end

    assign tp_win     = timing_pulse[`LL_WIN_TAP];
    assign tp_lckdly  = timing_pulse[`LL_ILOCK_TAP];
    assign min_signal = (intg >= intg_t'(`LL_SIG_MIN));

    always_comb begin
        state_nx = state;
        case (state)
            // Wait for lock-to-reference to be applied, then mask
            req_l2r: if (lock_ack && tp_mask) state_nx = qpkdet;
            // Peak detector ignored for one mask period
            qpkdet:  if (tp_mask) state_nx = winrst;
            winrst:  state_nx = wincnt;
            wincnt: begin
                // Window boundary wins over the threshold
                if (tp_win) begin
                    state_nx = winrst;
                end else if (min_signal && (`LL_ILOCK_WAIT == 0)) begin
                    state_nx = req_nrm;
                end else if (min_signal) begin
                    state_nx = iplck1;
                end
            end
            iplck1:  if (tp_lckdly) state_nx = iplck2;
            iplck2:  if (tp_lckdly) state_nx = req_nrm;
            req_nrm: if (!lock_ack) state_nx = cdr_nrm;
            // Link loss drops back, except during receiver calibration
            cdr_nrm: if (sync_fall && !calib_sync_hold) state_nx = req_l2r;
            default: state_nx = req_l2r;
        endcase
    end

    // Request moves together with entry into a request state
    always_comb begin
        lock_req_nx = lock_req;
        if (state_nx == req_l2r) begin
            lock_req_nx = 1'b1;
        end else if (state_nx == req_nrm) begin
            lock_req_nx = 1'b0;
        end
    end

    // Integrator cleared per window, counts non-idle cycles
    always_comb begin
        intg_nx = intg;
        if (state_nx == winrst) begin
            intg_nx = '0;
        end else if (state_nx == wincnt && !rx_idle_sync) begin
            intg_nx = intg + 1'b1;
        end
    end

    assign never_locked_nx = (state_nx == cdr_nrm) ? 1'b0 : never_locked;

    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            state        <= req_l2r;
            lock_req     <= 1'b1;
            intg         <= '0;
            never_locked <= 1'b1;
        end else begin
            state        <= state_nx;
            lock_req     <= lock_req_nx;
            intg         <= intg_nx;
            never_locked <= never_locked_nx;
        end
    end

endmodule

// ==== design/cdr_mode_ctrl.sv ====
// Lane master model; applies requested CDR lock modes after settling and acknowledges them
`timescale 1ns/1ns
`include "lane_lock_config.svh"

module cdr_mode_ctrl import lane_lock_pkg::*; (
    input  logic ctrl_clk,
    input  logic ctrl_srst_n,
    input  logic lock_req,
    output logic lock_ack,
    output logic cdr_lock_to_ref,
    output logic mode_applied
);

    // Last request seen, used to spot a new transaction
    logic req_q;
    logic req_chg;

    // Mode currently applied to the CDR, 1 is lock-to-reference
    logic mode_q;

    // Settling countdown, zero when idle
    settle_t settle_cnt;
    logic    settle_done;

    assign req_chg     = (lock_req != req_q);
    assign settle_done = (settle_cnt == settle_t'(1));

    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            req_q <= 1'b1;
        end else begin
            req_q <= lock_req;
        end
    end

    // Any request change restarts the settle time
    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            settle_cnt <= '0;
        end else if (req_chg) begin
            settle_cnt <= settle_t'(`LL_SETTLE_CYC - 1);
        end else if (settle_cnt != '0) begin
            settle_cnt <= settle_cnt - 1'b1;
        end
    end

    // Apply at the end of settling
    // A request that came back to the old mode leaves the CDR untouched
    always_ff @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            mode_q       <= 1'b1;
            mode_applied <= 1'b0;
        end else begin
            mode_applied <= 1'b0;
            if (settle_done && !req_chg && (req_q != mode_q)) begin
                mode_q       <= req_q;
                mode_applied <= 1'b1;
            end
        end
    end

    // Acknowledge echoes the mode now in force
    assign lock_ack        = mode_q;
    assign cdr_lock_to_ref = mode_q;

endmodule

// ==== design/lane_lock_top.sv ====
// Lane lock top level; timer, input side, lock FSM and CDR mode control wired together
`timescale 1ns/1ns

module lane_lock_top import lane_lock_pkg::*; (
    input  logic ctrl_clk,
    input  logic ctrl_srst_n,
    input  logic rx_idle,
    input  logic sync,
    input  logic calib_sync_hold,
    output logic cdr_lock_to_ref,
    output logic mode_applied
);

    pulse_t timing_pulse;
    logic   rx_idle_sync;
    logic   sync_fall;

    // Level request and acknowledge with the lane master
    logic   lock_req;
    logic   lock_ack;

    link_timer u_link_timer (
        .ctrl_clk     (ctrl_clk),
        .ctrl_srst_n  (ctrl_srst_n),
        .timing_pulse (timing_pulse)
    );

    lane_sync_in u_lane_sync_in (
        .ctrl_clk     (ctrl_clk),
        .ctrl_srst_n  (ctrl_srst_n),
        .rx_idle      (rx_idle),
        .sync         (sync),
        .rx_idle_sync (rx_idle_sync),
        .sync_fall    (sync_fall)
    );

    lock_manager u_lock_manager (
        .ctrl_clk        (ctrl_clk),
        .ctrl_srst_n     (ctrl_srst_n),
        .timing_pulse    (timing_pulse),
        .rx_idle_sync    (rx_idle_sync),
        .sync_fall       (sync_fall),
        .calib_sync_hold (calib_sync_hold),
        .lock_ack        (lock_ack),
        .lock_req        (lock_req)
    );

    cdr_mode_ctrl u_cdr_mode_ctrl (
        .ctrl_clk        (ctrl_clk),
        .ctrl_srst_n     (ctrl_srst_n),
        .lock_req        (lock_req),
        .lock_ack        (lock_ack),
        .cdr_lock_to_ref (cdr_lock_to_ref),
        .mode_applied    (mode_applied)
    );

endmodule

// ==== bench/lane_lock_checker.sv ====
// Lane lock checker; counts mode changes per test and compares the end state with the table
`timescale 1ns/1ns

module lane_lock_checker (
    input  logic ctrl_clk,
    input  logic ctrl_srst_n,
    input  logic cdr_lock_to_ref,
    input  logic mode_applied,
    input  logic test_end,
    input  int   test_id,
    input  logic exp_l2r,
    input  int   exp_strobes,
    output int   tests_checked,
    output int   tests_failed
);

    // mode_applied strobes seen since the previous test ended
    int   strobe_cnt;
    int   test_errs;
    logic applied_q;

    // Compare the state at the end of a test with the table row
    task automatic check_test();
        if (cdr_lock_to_ref !== exp_l2r) begin
            $display("[FAIL] test %0d cdr_lock_to_ref expected %0h got %0h",
                     test_id, exp_l2r, cdr_lock_to_ref);
            test_errs++;
        end
        if (strobe_cnt != exp_strobes) begin
            $display("[FAIL] test %0d mode_applied count expected %0h got %0h",
                     test_id, exp_strobes, strobe_cnt);
            test_errs++;
        end
        tests_checked++;
        if (test_errs == 0) begin
            $display("test %0d ok: cdr_lock_to_ref %0h after %0d mode changes",
                     test_id, cdr_lock_to_ref, strobe_cnt);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d wrong results", test_id, test_errs);
        end
    endtask

    always @(posedge ctrl_clk or negedge ctrl_srst_n) begin
        if (!ctrl_srst_n) begin
            strobe_cnt    = 0;
            test_errs     = 0;
            applied_q     = 1'b0;
            tests_checked = 0;
            tests_failed  = 0;
        end else begin
            // The lane master strobes once per applied change
            if (mode_applied && applied_q) begin
                $display("test %0d mode_applied stayed high for more than one cycle", test_id);
                test_errs++;
            end
            if (mode_applied) begin
                strobe_cnt = strobe_cnt + 1;
            end
            applied_q = mode_applied;
            if (test_end) begin
                check_test();
                // Strobes between two tests count towards the next one
                strobe_cnt = 0;
                test_errs  = 0;
            end
        end
    end

endmodule

// ==== bench/lane_lock_tb.sv ====
// Lane lock testbench; reads the test table, drives the lane inputs and bounds the run
`timescale 1ns/1ns

module lane_lock_tb;

    // Eight columns per table row
    localparam int COLS     = 8;
    localparam int MAX_ROWS = 16;
    // Covers reset and the last framing cycles
    localparam int MARGIN   = 200;

    logic ctrl_clk;
    logic ctrl_srst_n;
    logic rx_idle;
    logic sync;
    logic calib_sync_hold;
    logic cdr_lock_to_ref;
    logic mode_applied;

    // Test framing and expected values towards the checker
    logic test_end;
    int   test_id;
    logic exp_l2r;
    int   exp_strobes;
    int   tests_checked;
    int   tests_failed;

    logic [31:0] test_mem [0:COLS*MAX_ROWS-1];
    int          num_tests;
    int          watchdog_cycles;
    logic        tests_loaded;

    lane_lock_top UUT (
        .ctrl_clk        (ctrl_clk),
        .ctrl_srst_n     (ctrl_srst_n),
        .rx_idle         (rx_idle),
        .sync            (sync),
        .calib_sync_hold (calib_sync_hold),
        .cdr_lock_to_ref (cdr_lock_to_ref),
        .mode_applied    (mode_applied)
    );

    lane_lock_checker u_checker (
        .ctrl_clk        (ctrl_clk),
        .ctrl_srst_n     (ctrl_srst_n),
        .cdr_lock_to_ref (cdr_lock_to_ref),
        .mode_applied    (mode_applied),
        .test_end        (test_end),
        .test_id         (test_id),
        .exp_l2r         (exp_l2r),
        .exp_strobes     (exp_strobes),
        .tests_checked   (tests_checked),
        .tests_failed    (tests_failed)
    );

    always #10 ctrl_clk = ~ctrl_clk;

    // Count rows up to the end marker and size the watchdog from the waits
    task automatic load_tests();
        int row;
        $readmemh("bench/lane_lock_tests.txt", test_mem);
        for (row = 0; row < MAX_ROWS; row++) begin
            if ($isunknown(test_mem[row*COLS]) || test_mem[row*COLS] == 32'h0) begin
                break;
            end
            num_tests++;
            watchdog_cycles += int'(test_mem[row*COLS+7]) + 2;
        end
    endtask

    // Drive one table row for its wait length, then mark the end for the checker
    task automatic run_test(input int row);
        int   base;
        int   duty;
        int   wait_cyc;
        logic sync_lvl;
        logic hold_lvl;
        logic drop;
        base     = row * COLS;
        duty     = int'(test_mem[base+1]);
        sync_lvl = test_mem[base+2][0];
        hold_lvl = test_mem[base+3][0];
        drop     = test_mem[base+4][0];
        wait_cyc = int'(test_mem[base+7]);
        for (int c = 0; c < wait_cyc; c++) begin
            @(posedge ctrl_clk);
            test_id         <= int'(test_mem[base]);
            exp_l2r         <= test_mem[base+5][0];
            exp_strobes     <= int'(test_mem[base+6]);
            // Non-idle cycles lead each 64-cycle block
            rx_idle         <= ((c % 64) >= duty);
            // Link-up falls two cycles into a drop test
            sync            <= (drop && c >= 2) ? 1'b0 : sync_lvl;
            calib_sync_hold <= hold_lvl;
        end
        @(posedge ctrl_clk);
        test_end   <= 1'b1;
        @(posedge ctrl_clk);
        test_end   <= 1'b0;
    endtask

    initial begin
        ctrl_clk        = 1'b0;
        ctrl_srst_n     = 1'b0;
        rx_idle         = 1'b1;
        sync            = 1'b0;
        calib_sync_hold = 1'b0;
        test_end        = 1'b0;
        test_id         = 0;
        exp_l2r         = 1'b1;
        exp_strobes     = 0;
        num_tests       = 0;
        watchdog_cycles = MARGIN;
        tests_loaded    = 1'b0;
        load_tests();
        tests_loaded = 1'b1;
        repeat (2) @(posedge ctrl_clk);
        ctrl_srst_n <= 1'b1;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        repeat (2) @(posedge ctrl_clk);
        if (num_tests == 0) begin
            $display("no test rows were read from the test table");
        end
        if (tests_checked != num_tests) begin
            $display("checker finished %0d of %0d tests", tests_checked, num_tests);
        end
        $display("tests %0d, passed %0d, failed %0d",
                 num_tests, tests_checked - tests_failed, tests_failed);
        if (num_tests > 0 && tests_checked == num_tests && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog, all waits plus framing and margin
    initial begin
        wait (tests_loaded);
        repeat (watchdog_cycles) @(posedge ctrl_clk);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== files.f ====
+incdir+design
design/lane_lock_pkg.sv
design/link_timer.sv
design/lane_sync_in.sv
design/lock_manager.sv
design/cdr_mode_ctrl.sv
design/lane_lock_top.sv
bench/lane_lock_checker.sv
bench/lane_lock_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the lane lock testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f files.f --top-module lane_lock_tb -o lane_lock_sim

out=$(./obj_dir/lane_lock_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF '>>> PASS'; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// ==== bench/lane_lock_tests.txt ====
// Lane lock test table, one test per row, every field in hex
// Columns: test duty sync hold drop exp_cdr_lock_to_ref exp_mode_applied_count wait_cycles
// Duty is non-idle cycles per 64-cycle block, drop pulls sync low two cycles in
// Receiver idle after reset, CDR stays on the reference
1 00 0 0 0 1 0 258
// Weak signal below the window threshold
2 14 0 0 0 1 0 190
// Full signal, first lock with the short quiet time
3 40 1 0 0 0 1 190
// Link-up falls during receiver calibration
4 40 1 1 1 0 0 64
// Link-up falls, back to lock-to-reference
5 40 1 0 1 1 1 32
// Relock behind the longer debounce mask
6 40 1 0 0 0 1 258
// All-zero row ends the table
0 00 0 0 0 0 0 0
